/* project.f */
source/stream_pkg.sv
source/model_pkg.sv
source/stream_slice.sv
source/word_decode.sv
source/dense_execute.sv
source/result_serialize.sv
source/de1soc_top.sv
verification/adapter_props.sv
verification/adapter_tb.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the stream adapter testbench with Verilator
set -e
cd "$(dirname "$0")"

log_file=sim.log

# width lint from the RTL is reported but does not stop the build
verilator --binary --timing --assert -Wno-fatal \
    --top-module adapter_tb -f project.f -o adapter_sim

./obj_dir/adapter_sim | tee "$log_file"

if grep -qx '\*\* PASS \*\*' "$log_file"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi

/* source/de1soc_top.sv */
// DE1-SoC host stream adapter
`default_nettype none

module de1soc_top (
    input  logic                             clock,
    input  logic                             reset,
    input  logic [stream_pkg::word_bits-1:0] in_data,
    input  logic                             in_valid,
    output logic                             upstream_stall,
    output logic [stream_pkg::word_bits-1:0] out_data,
    output logic                             out_valid,
    input  logic                             downstream_stall
);
    stream_pkg::in_word_t    host_word;
    logic                    host_valid;
    logic                    word_stall;
    model_pkg::sample_t      sample;
    logic                    sample_valid;
    logic                    stage_reset;   // hard reset or soft reset word
    logic                    exec_ready;
    model_pkg::channel_vec_t result;
    logic                    result_valid;
    logic                    result_taken;
    stream_pkg::out_word_t   ser_word;
    logic                    ser_valid;
    logic                    ser_stall;

    stream_slice #(.payload_t(stream_pkg::in_word_t)) input_slice (
        .clock            (clock),
        .reset            (reset),
        .in_data          (in_data),
        .in_valid         (in_valid),
        .out_data         (host_word),
        .out_valid        (host_valid),
        .downstream_stall (word_stall),
        .upstream_stall   (upstream_stall)
    );

    word_decode decode (
        .clock        (clock),
        .reset        (reset),
        .word         (host_word),
        .word_valid   (host_valid),
        .exec_ready   (exec_ready),
        .sample       (sample),
        .sample_valid (sample_valid),
        .stage_reset  (stage_reset),
        .word_stall   (word_stall)
    );

    dense_execute execute (
        .clock        (clock),
        .reset        (stage_reset),
        .sample       (sample),
        .sample_valid (sample_valid),
        .in_ready     (exec_ready),
        .result       (result),
        .result_valid (result_valid),
        .result_taken (result_taken)
    );

    result_serialize serialize (
        .clock            (clock),
        .reset            (stage_reset),
        .vector           (result),
        .vector_valid     (result_valid),
        .vector_taken     (result_taken),
        .word             (ser_word),
        .word_valid       (ser_valid),
        .downstream_stall (ser_stall)
    );

    stream_slice #(.payload_t(stream_pkg::out_word_t)) output_slice (
        .clock            (clock),
        .reset            (reset),
        .in_data          (ser_word),
        .in_valid         (ser_valid),
        .out_data         (out_data),
        .out_valid        (out_valid),
        .downstream_stall (downstream_stall),
        .upstream_stall   (ser_stall)
    );

endmodule

`default_nettype wire

/* source/dense_execute.sv */
// Dense layer frame accumulator
`default_nettype none

module dense_execute (
    input  logic                    clock,
    input  logic                    reset,
    input  model_pkg::sample_t      sample,
    input  logic                    sample_valid,
    output logic                    in_ready,
    output model_pkg::channel_vec_t result,
    output logic                    result_valid,
    input  logic                    result_taken
);
    localparam int channels = model_pkg::out_channels;
    localparam int acc_bits = model_pkg::acc_bits;

    // saturation bounds for an 18 bit signed result
    localparam logic signed [acc_bits-1:0] sat_max = (1 <<< (model_pkg::value_bits - 1)) - 1;
    localparam logic signed [acc_bits-1:0] sat_min = -(1 <<< (model_pkg::value_bits - 1));

    logic signed [acc_bits-1:0] acc [channels];
    logic signed [acc_bits-1:0] term [channels];
    logic signed [acc_bits-1:0] sum_next [channels];
    logic [model_pkg::index_bits-1:0] index;   // sample position, stops at 28
    logic weighted;
    logic accept;

    // shift out the fraction bits and clamp to the result range
    function automatic model_pkg::value_t rescale(input logic signed [acc_bits-1:0] sum);
        logic signed [acc_bits-1:0] shifted;
        shifted = sum >>> model_pkg::q_frac;
        if (shifted > sat_max) begin
            return model_pkg::value_t'(sat_max);
        end
        if (shifted < sat_min) begin
            return model_pkg::value_t'(sat_min);
        end
        return model_pkg::value_t'(shifted);
    endfunction

    assign in_ready = !result_valid;   // one held result blocks new samples
    assign accept   = sample_valid && in_ready;
    assign weighted = index < model_pkg::input_width;

    always_comb begin
        for (int c = 0; c < channels; c++) begin
            term[c] = sample.value * model_pkg::weight_of(c, int'(index));
            sum_next[c] = weighted ? acc[c] + term[c] : acc[c];   // late samples add nothing
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int c = 0; c < channels; c++) begin
                acc[c] <= '0;
            end
            index        <= '0;
            result_valid <= 1'b0;
        end else begin
            if (result_taken) begin
                result_valid <= 1'b0;
            end
            if (accept) begin
                if (sample.last) begin
                    // frame done, start the next one from zero
                    for (int c = 0; c < channels; c++) begin
                        acc[c] <= '0;
                    end
                    index        <= '0;
                    result_valid <= 1'b1;
                end else begin
                    for (int c = 0; c < channels; c++) begin
                        acc[c] <= sum_next[c];
                    end
                    if (weighted) begin
                        index <= index + 1'b1;
                    end
                end
            end
        end
    end

    // result register, written with the last sample of a frame
    always_ff @(posedge clock) begin
        if (accept && sample.last) begin
            for (int c = 0; c < channels; c++) begin
                result[c] <= rescale(sum_next[c]);
            end
        end
    end

endmodule

`default_nettype wire

/* source/model_pkg.sv */
// Dense layer model definitions
`default_nettype none

package model_pkg;

    localparam int value_bits   = 18;
    localparam int q_frac       = 8;
    localparam int input_width  = 28;   // weighted samples per frame
    localparam int out_channels = 10;
    localparam int acc_bits     = 40;   // 28 products of 18x5 bits fit easily
    localparam int index_bits   = $clog2(input_width + 1);
    localparam int weight_bits  = 5;    // weights span -15..15

    typedef logic signed [value_bits-1:0]  value_t;
    typedef logic signed [weight_bits-1:0] weight_t;

    // decoded sample handed from decode to execute
    typedef struct packed {
        value_t value;
        logic   last;
    } sample_t;

    // one result per channel, elements stay signed through value_t
    typedef value_t [out_channels-1:0] channel_vec_t;

    // fixed weight of channel c for sample index i
    function automatic weight_t weight_of(input int c, input int i);
        int raw;
        raw = (7 * c + 3 * i) % 31;
        return weight_t'(raw - 15);   // raw multiplier, no Q scaling
    endfunction

endpackage

`default_nettype wire

/* source/result_serialize.sv */
// Result vector serializer
`default_nettype none

module result_serialize (
    input  logic                    clock,
    input  logic                    reset,
    input  model_pkg::channel_vec_t vector,
    input  logic                    vector_valid,
    output logic                    vector_taken,
    output stream_pkg::out_word_t   word,
    output logic                    word_valid,
    input  logic                    downstream_stall
);
    localparam int chan_bits       = $clog2(model_pkg::out_channels);
    localparam int word_value_bits = stream_pkg::out_value_bits;
    localparam logic [chan_bits-1:0] last_channel = chan_bits'(model_pkg::out_channels - 1);

    logic                    buffer_valid;
    model_pkg::channel_vec_t buffer;
    logic [chan_bits-1:0]    channel;   // channel on the output word
    model_pkg::value_t       current;

    // load only into an empty buffer
    assign vector_taken = vector_valid && !buffer_valid;

    always_ff @(posedge clock) begin
        if (reset) begin
            buffer_valid <= 1'b0;
            channel      <= '0;
        end else if (vector_taken) begin
            buffer_valid <= 1'b1;
            channel      <= '0;
        end else if (buffer_valid && !downstream_stall) begin
            if (channel == last_channel) begin
                buffer_valid <= 1'b0;   // vector fully sent
                channel      <= '0;
            end else begin
                channel <= channel + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (vector_taken) begin
            buffer <= vector;
        end
    end

    assign current    = buffer[channel];
    assign word_valid = buffer_valid;

    always_comb begin
        word.zero  = 1'b0;
        word.last  = buffer_valid && (channel == last_channel);
        word.value = word_value_bits'(current);   // sign extends to 30 bits
    end

endmodule

`default_nettype wire

/* source/stream_pkg.sv */
// Host stream word formats
`default_nettype none

package stream_pkg;

    localparam int word_bits      = 32;
    localparam int spare_bits     = 12;
    localparam int sample_bits    = 18;
    localparam int out_value_bits = 30;

    // word written by the host
    typedef struct packed {
        logic                   soft_reset;   // bit 31, clears execute and result
        logic                   last;         // bit 30, last sample of frame
        logic [spare_bits-1:0]  spare;        // bits 29:18, unused
        logic [sample_bits-1:0] sample;       // signed Q8 sample
    } in_word_t;

    // word read back by the host, one channel per word
    typedef struct packed {
        logic                      zero;      // always low
        logic                      last;      // set on the tenth word
        logic [out_value_bits-1:0] value;     // sign-extended channel result
    } out_word_t;

endpackage

`default_nettype wire

/* source/stream_slice.sv */
// Single entry register slice
`default_nettype none

module stream_slice #(
    parameter type payload_t = logic
) (
    input  logic     clock,
    input  logic     reset,
    input  payload_t in_data,
    input  logic     in_valid,
    output payload_t out_data,
    output logic     out_valid,
    input  logic     downstream_stall,
    output logic     upstream_stall
);
    logic load;

    assign load = !out_valid || !downstream_stall;   // empty or draining
    assign upstream_stall = out_valid && downstream_stall;

    always_ff @(posedge clock) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (load) begin
            out_valid <= in_valid;
        end
    end

    // payload follows the valid bit, held while stalled
    always_ff @(posedge clock) begin
        if (load) begin
            out_data <= in_data;
        end
    end

endmodule

`default_nettype wire

/* source/word_decode.sv */
// Host word decoder
`default_nettype none

module word_decode (
    input  logic                 clock,
    input  logic                 reset,
    input  stream_pkg::in_word_t word,
    input  logic                 word_valid,
    input  logic                 exec_ready,
    output model_pkg::sample_t   sample,
    output logic                 sample_valid,
    output logic                 stage_reset,
    output logic                 word_stall
);
    logic soft_word;   // soft reset request on the slice output

    assign soft_word = word_valid && word.soft_reset;

    // clears execute and result, the slices keep their words
    assign stage_reset = reset || soft_word;

    assign sample.value = word.sample;
    assign sample.last  = word.last;

    assign sample_valid = word_valid && !word.soft_reset;

    // reset requests are never held back
    assign word_stall = word_valid && !word.soft_reset && !exec_ready;

endmodule

`default_nettype wire

/* verification/adapter_props.sv */
// Output stream assertions
`default_nettype none

module adapter_props (
    input logic        clock,
    input logic        reset,
    input logic [31:0] out_data,
    input logic        out_valid,
    input logic        downstream_stall
);

    // a stalled word stays on the port until the host takes it
    hold_stalled_word: assert property (
        @(posedge clock) disable iff (reset)
        out_valid && downstream_stall |=> out_valid && $stable(out_data)
    ) else $error("output word changed while stalled");

    // end of frame marker only on a valid word
    last_needs_valid: assert property (
        @(posedge clock) disable iff (reset)
        $rose(out_data[30]) |-> out_valid
    ) else $error("out_data bit 30 rose without out_valid");

    top_bit_zero: assert property (
        @(posedge clock) disable iff (reset)
        out_valid |-> !out_data[31]
    ) else $error("out_data bit 31 set on a valid word");

endmodule

bind de1soc_top adapter_props props (
    .clock            (clock),
    .reset            (reset),
    .out_data         (out_data),
    .out_valid        (out_valid),
    .downstream_stall (downstream_stall)
);

`default_nettype wire

/* verification/adapter_tb.sv */
// Stream adapter testbench
`default_nettype none

module adapter_tb;

    localparam int weighted_samples = 28;
    localparam int frac_bits        = 8;
    localparam int channels         = 10;
    localparam int max_value        = 131071;
    localparam int min_value        = -131072;
    // about 12 frames of up to 35 samples plus drain waits, doubled for stalls, with margin
    localparam int timeout_cycles   = 4000;

    logic        clock;
    logic        reset;
    logic [31:0] in_data;
    logic        in_valid;
    logic        upstream_stall;
    logic [31:0] out_data;
    logic        out_valid;
    logic        downstream_stall = 1'b0;
    logic        stall_random = 1'b0;   // random back-pressure on the output

    int          frame[$];              // samples of the frame being built
    logic [31:0] expected[$];
    logic [31:0] got[$];
    int          error_count = 0;
    int          check_count = 0;
    int          cycle_count;

    de1soc_top uut (
        .clock            (clock),
        .reset            (reset),
        .in_data          (in_data),
        .in_valid         (in_valid),
        .upstream_stall   (upstream_stall),
        .out_data         (out_data),
        .out_valid        (out_valid),
        .downstream_stall (downstream_stall)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    // host side takes a word on every unstalled valid edge
    always @(posedge clock) begin
        if (out_valid && !downstream_stall) begin
            got.push_back(out_data);
        end
    end

    always @(posedge clock) begin
        #1;
        if (stall_random) begin
            downstream_stall = ($urandom % 3) == 0;
        end else begin
            downstream_stall = 1'b0;
        end
    end

    initial begin : watchdog
        cycle_count = 0;
        while (cycle_count < timeout_cycles) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("timeout: tests did not finish within %0d cycles", timeout_cycles);
        $display("** FAIL **");
        $finish;
    end

    function automatic int sample_weight(input int c, input int i);
        return ((7 * c + 3 * i) % 31) - 15;
    endfunction

    // reference sum, rescale and clamp for one channel
    function automatic int channel_result(input int samples[$], input int c);
        longint sum;
        longint shifted;
        int     n;
        sum = 0;
        n = (samples.size() < weighted_samples) ? samples.size() : weighted_samples;
        for (int i = 0; i < n; i++) begin
            sum += longint'(samples[i]) * longint'(sample_weight(c, i));
        end
        shifted = sum >>> frac_bits;
        if (shifted > max_value) shifted = max_value;
        if (shifted < min_value) shifted = min_value;
        return int'(shifted);
    endfunction

    function automatic int random_sample();
        logic signed [17:0] raw;
        raw = 18'($urandom);
        return int'(raw);
    endfunction

    task automatic add_expected();
        for (int c = 0; c < channels; c++) begin
            expected.push_back({1'b0, c == channels - 1, 30'(channel_result(frame, c))});
        end
    endtask

    // called a small delay after a rising edge, returns at the same phase
    task automatic send_word(input logic [31:0] w);
        in_data  = w;
        in_valid = 1'b1;
        while (upstream_stall) begin
            @(posedge clock);
            #1;
        end
        @(posedge clock);   // taken at this edge
        #1;
        in_valid = 1'b0;
    endtask

    task automatic send_frame();
        logic last_flag;
        for (int i = 0; i < frame.size(); i++) begin
            last_flag = (i == frame.size() - 1);
            send_word({1'b0, last_flag, 12'b0, 18'(frame[i])});
        end
        add_expected();
        frame.delete();
    endtask

    task automatic check_outputs(input string name);
        int waited;
        waited = 0;
        while (got.size() < expected.size() && waited < 400) begin
            @(posedge clock);
            waited++;
        end
        repeat (20) @(posedge clock);   // room for any extra word
        #1;
        check_count++;
        if (got.size() < expected.size()) begin
            error_count++;
            $display("%s: only %0d of %0d output words arrived", name, got.size(),
                     expected.size());
        end else if (got.size() > expected.size()) begin
            error_count++;
            $display("%s: %0d output words arrived, %0d expected", name, got.size(),
                     expected.size());
        end
        for (int i = 0; i < got.size() && i < expected.size(); i++) begin
            check_count++;
            if (got[i] !== expected[i]) begin
                error_count++;
                $display("[ERROR] %s word %0d: expected %h, actual %h", name, i,
                         expected[i], got[i]);
            end
        end
        got.delete();
        expected.delete();
    endtask

    task automatic reset_and_small_frame();
        check_count += 2;
        if (out_valid !== 1'b0) begin
            error_count++;
            $display("[ERROR] reset_state out_valid: expected 0, actual %b", out_valid);
        end
        if (upstream_stall !== 1'b0) begin
            error_count++;
            $display("[ERROR] reset_state upstream_stall: expected 0, actual %b",
                     upstream_stall);
        end
        frame = '{256, -512, 1000, 37, -3};
        send_frame();
        check_outputs("small_frame");
    endtask

    // full-scale frames, then frames whose signs follow channel 0 weights
    task automatic full_scale_frames();
        for (int i = 0; i < weighted_samples; i++) frame.push_back(max_value);
        send_frame();
        for (int i = 0; i < weighted_samples; i++) frame.push_back(min_value);
        send_frame();
        for (int i = 0; i < weighted_samples; i++) begin
            frame.push_back(sample_weight(0, i) >= 0 ? max_value : min_value);
        end
        send_frame();
        for (int i = 0; i < weighted_samples; i++) begin
            frame.push_back(sample_weight(0, i) >= 0 ? min_value : max_value);
        end
        send_frame();
        check_outputs("full_scale");
    endtask

    task automatic long_frame();
        for (int i = 0; i < 35; i++) frame.push_back(random_sample());
        send_frame();   // model weights only the first 28
        check_outputs("long_frame");
    endtask

    // back-pressure stays on until the last frame has drained
    task automatic random_back_to_back();
        int length;
        stall_random = 1'b1;
        for (int f = 0; f < 3; f++) begin
            length = 1 + ($urandom % 35);
            for (int i = 0; i < length; i++) frame.push_back(random_sample());
            send_frame();
        end
        check_outputs("random_frames");
        stall_random = 1'b0;
    endtask

    task automatic soft_reset_mid_frame();
        for (int i = 0; i < 12; i++) begin
            send_word({1'b0, 1'b0, 12'b0, 18'(random_sample())});
        end
        send_word(32'h8000_0000);   // soft reset, partial sums dropped
        for (int i = 0; i < 7; i++) frame.push_back(random_sample());
        send_frame();
        check_outputs("soft_reset");
    endtask

    initial begin
        void'($urandom(32'hb3fbc283));
        reset    = 1'b1;
        in_data  = '0;
        in_valid = 1'b0;
        repeat (10) @(posedge clock);
        #1;
        reset = 1'b0;

        reset_and_small_frame();
        full_scale_frames();
        long_frame();
        random_back_to_back();
        soft_reset_mid_frame();

        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire
